// ==== hdl/rvPipe_cfg.svh ====
// widths assume RV32I with 32 registers; the pc step is fixed at 4 (no compressed instructions)
`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

// data and pc width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REGS 32

// pc distance between instructions
// AUIPC adds its own pc, so the pipeline itself never steps the pc
`define RV_PC_STEP 4

`endif

// ==== hdl/rvPipePkg.sv ====
// types for the three-stage pipeline; payloads are packed so an all-zero value is a bubble
`default_nettype none

`include "rvPipe_cfg.svh"

package rvPipePkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB    // LUI
    } aluOpT;

    // payload of the decode register
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } fetchT;

    // payload of the execute register
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        aluOpT               aluOp;
        logic [`RV_XLEN-1:0] rs1Val;
        logic [`RV_XLEN-1:0] rs2Val;
        logic [`RV_XLEN-1:0] imm;
        logic                useImm;  // operand b from imm, not rs2
        logic                usePc;   // operand a from pc, not rs1
    } decodedT;

    // payload of the result register
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;
    } resultT;

endpackage

`default_nettype wire

// ==== hdl/writeBackIf.sv ====
// one write-back per cycle; wbEn is never high for x0
`default_nettype none

`include "rvPipe_cfg.svh"

interface writeBackIf;
    logic                wbEn;
    logic [4:0]          wbRd;
    logic [`RV_XLEN-1:0] wbData;
    logic [`RV_XLEN-1:0] wbPc;    // pc of the writing instruction, for tracing

    modport src  (output wbEn, wbRd, wbData, wbPc);
    modport sink (input wbEn, wbRd, wbData, wbPc);
    modport fwd  (input wbEn, wbRd, wbData);
endinterface

`default_nettype wire

// ==== hdl/stageReg.sv ====
// payloadT must be a packed type whose all-zero value means empty (valid bit low)
`default_nettype none

module stageReg #(
    parameter type payloadT = rvPipePkg::fetchT
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;    // bubble
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
// reads are combinational and see a same-cycle write; x0 always reads zero
`default_nettype none

`include "rvPipe_cfg.svh"

module regFile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rs1Data,
    output logic [`RV_XLEN-1:0] rs2Data,
    writeBackIf.sink            wb
);

    logic [`RV_XLEN-1:0] regs [`RV_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wbEn) begin
            regs[wb.wbRd] <= wb.wbData;
        end
    end

    // write-through so decode sees the result being written this cycle
    function automatic logic [`RV_XLEN-1:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wb.wbEn && wb.wbRd == addr) begin
            return wb.wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
// decodes only OP, OP-IMM, LUI and AUIPC; any other opcode leaves as a bubble
`default_nettype none

`include "rvPipe_cfg.svh"

module decodeStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                instValid,
    input  logic [31:0]         inst,
    input  logic [`RV_XLEN-1:0] pc,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    input  logic [`RV_XLEN-1:0] rs1Data,
    input  logic [`RV_XLEN-1:0] rs2Data,
    output rvPipePkg::decodedT  dec
);
    import rvPipePkg::*;

    localparam logic [6:0] opcOp    = 7'b0110011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcLui   = 7'b0110111;
    localparam logic [6:0] opcAuipc = 7'b0010111;
    localparam logic [6:0] funct7Alt = 7'b0100000;

    fetchT fetchIn;
    fetchT fetchQ;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immU;
    logic                legal;

    assign fetchIn = '{valid: instValid, pc: pc, inst: inst};

    stageReg #(.payloadT(fetchT)) fetchReg (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .d     (fetchIn),
        .q     (fetchQ)
    );

    assign opcode = fetchQ.inst[6:0];
    assign funct3 = fetchQ.inst[14:12];
    assign funct7 = fetchQ.inst[31:25];
    assign rs1    = fetchQ.inst[19:15];
    assign rs2    = fetchQ.inst[24:20];
    assign immI   = {{(`RV_XLEN-12){fetchQ.inst[31]}}, fetchQ.inst[31:20]};
    assign immU   = {fetchQ.inst[31:12], 12'b0};

    // alt picks SUB over ADD and SRA over SRL
    function automatic aluOpT opFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_comb begin
        legal      = 1'b1;
        dec.aluOp  = aluAdd;
        dec.imm    = immI;
        dec.useImm = 1'b0;
        dec.usePc  = 1'b0;
        case (opcode)
            opcOp: begin
                dec.aluOp = opFromFunct3(funct3, funct7[5]);
                legal = funct7 == 7'd0
                    || (funct7 == funct7Alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opcOpImm: begin
                dec.aluOp  = opFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
                dec.useImm = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = funct7 == 7'd0;
                end else if (funct3 == 3'b101) begin
                    legal = funct7 == 7'd0 || funct7 == funct7Alt;
                end
            end
            opcLui: begin
                dec.aluOp  = aluPassB;
                dec.imm    = immU;
                dec.useImm = 1'b1;
            end
            opcAuipc: begin
                dec.imm    = immU;
                dec.useImm = 1'b1;
                dec.usePc  = 1'b1;  // pc + upper imm
            end
            default: legal = 1'b0;
        endcase
        dec.valid  = fetchQ.valid && legal;
        dec.pc     = fetchQ.pc;
        dec.rd     = fetchQ.inst[11:7];
        dec.rs1    = rs1;
        dec.rs2    = rs2;
        dec.rs1Val = rs1Data;
        dec.rs2Val = rs2Data;
    end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
// forwards only from the result register; older values come through the register file
`default_nettype none

`include "rvPipe_cfg.svh"

module executeStage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  rvPipePkg::decodedT dec,
    writeBackIf.fwd            fwd,
    output rvPipePkg::resultT  res
);
    import rvPipePkg::*;

    decodedT exQ;

    logic [`RV_XLEN-1:0] rs1Val;
    logic [`RV_XLEN-1:0] rs2Val;
    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] aluOut;
    logic [4:0]          shamt;

    stageReg #(.payloadT(decodedT)) execReg (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .d     (dec),
        .q     (exQ)
    );

    // wbEn already excludes x0
    assign rs1Val = (fwd.wbEn && fwd.wbRd == exQ.rs1) ? fwd.wbData : exQ.rs1Val;
    assign rs2Val = (fwd.wbEn && fwd.wbRd == exQ.rs2) ? fwd.wbData : exQ.rs2Val;

    assign opA   = exQ.usePc ? exQ.pc : rs1Val;
    assign opB   = exQ.useImm ? exQ.imm : rs2Val;
    assign shamt = opB[4:0];

    always_comb begin
        case (exQ.aluOp)
            aluAdd:   aluOut = opA + opB;
            aluSub:   aluOut = opA - opB;
            aluSll:   aluOut = opA << shamt;
            aluSlt:   aluOut = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu:  aluOut = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            aluXor:   aluOut = opA ^ opB;
            aluSrl:   aluOut = opA >> shamt;
            aluSra:   aluOut = $signed(opA) >>> shamt;
            aluOr:    aluOut = opA | opB;
            aluAnd:   aluOut = opA & opB;
            aluPassB: aluOut = opB;
            default:  aluOut = opA + opB;
        endcase
    end

    // flush also kills the instruction leaving execute, so three in flight are dropped
    assign res.valid = exQ.valid && !flush;
    assign res.pc    = exQ.pc;
    assign res.rd    = exQ.rd;
    assign res.value = aluOut;

endmodule

`default_nettype wire

// ==== hdl/resultStage.sv ====
// retire outputs come straight from the result register and include x0 writes
`default_nettype none

`include "rvPipe_cfg.svh"

module resultStage (
    input  logic                clk,
    input  logic                reset,
    input  rvPipePkg::resultT   res,
    writeBackIf.src             wb,
    output logic                retireValid,
    output logic [`RV_XLEN-1:0] retirePc,
    output logic [4:0]          retireRd,
    output logic [`RV_XLEN-1:0] retireData
);
    import rvPipePkg::*;

    resultT resQ;

    stageReg #(.payloadT(resultT)) resReg (
        .clk   (clk),
        .reset (reset),
        .flush (1'b0),  // flush acts upstream
        .d     (res),
        .q     (resQ)
    );

    assign wb.wbEn   = resQ.valid && resQ.rd != 5'd0;
    assign wb.wbRd   = resQ.rd;
    assign wb.wbData = resQ.value;
    assign wb.wbPc   = resQ.pc;

    assign retireValid = resQ.valid;
    assign retirePc    = resQ.pc;
    assign retireRd    = resQ.rd;
    assign retireData  = resQ.value;

endmodule

`default_nettype wire

// ==== hdl/rvPipe.sv ====
// fixed three-cycle latency, one instruction per cycle, no back-pressure and no fetch
`default_nettype none

`include "rvPipe_cfg.svh"

module rvPipe (
    input  logic                clk,
    input  logic                reset,
    input  logic                instValid,
    input  logic [31:0]         inst,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic                flush,
    output logic                retireValid,
    output logic [`RV_XLEN-1:0] retirePc,
    output logic [4:0]          retireRd,
    output logic [`RV_XLEN-1:0] retireData
);
    import rvPipePkg::*;

    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    decodedT             dec;
    resultT              res;

    writeBackIf wbIf ();

    decodeStage decodeStage_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .dec       (dec)
    );

    regFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wbIf)
    );

    executeStage executeStage_i (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .dec   (dec),
        .fwd   (wbIf),
        .res   (res)
    );

    resultStage resultStage_i (
        .clk         (clk),
        .reset       (reset),
        .res         (res),
        .wb          (wbIf),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

endmodule

`default_nettype wire

// ==== bench/rvPipe_assertions.sv ====
// samples top-level ports on the rising edge; the forward retire check covers only LUI and AUIPC
`default_nettype none

`include "rvPipe_cfg.svh"

module rvPipe_assertions (
    input logic                clk,
    input logic                reset,
    input logic                instValid,
    input logic [31:0]         inst,
    input logic [`RV_XLEN-1:0] pc,
    input logic                flush,
    input logic                retireValid,
    input logic [`RV_XLEN-1:0] retirePc,
    input logic [4:0]          retireRd,
    input logic                wbEn,
    input logic [`RV_XLEN-1:0] wbPc
);

    logic alwaysLegal;

    // opcodes with no illegal encodings
    assign alwaysLegal = inst[6:0] == 7'b0110111 || inst[6:0] == 7'b0010111;

    noRetireInReset: assert property (@(posedge clk) reset |-> !retireValid)
        else $error("retireValid high while reset is active");

    // the write traces back to the instruction three edges earlier, whose rd is not x0
    noX0WriteBack: assert property (@(posedge clk) disable iff (reset)
        wbEn |-> $past(inst[11:7], 3) != 5'd0 && retireRd == $past(inst[11:7], 3)
            && wbPc == $past(pc, 3))
        else $error("write-back to x0 or for a different instruction");

    // every retire traces back to an unflushed instruction three edges earlier
    retireHasSource: assert property (@(posedge clk) disable iff (reset)
        retireValid |-> $past(instValid, 3) && retirePc == $past(pc, 3)
            && !$past(flush, 3) && !$past(flush, 2) && !$past(flush, 1))
        else $error("retire without a matching accepted instruction");

    acceptedRetires: assert property (@(posedge clk) disable iff (reset)
        instValid && alwaysLegal && !flush ##1 !flush ##1 !flush |=> retireValid)
        else $error("accepted instruction did not retire after three cycles");

endmodule

bind rvPipe rvPipe_assertions rvPipeAsrt_i (
    .clk         (clk),
    .reset       (reset),
    .instValid   (instValid),
    .inst        (inst),
    .pc          (pc),
    .flush       (flush),
    .retireValid (retireValid),
    .retirePc    (retirePc),
    .retireRd    (retireRd),
    .wbEn        (wbIf.wbEn),
    .wbPc        (wbIf.wbPc)
);

`default_nettype wire

// ==== bench/rvPipeTb.sv ====
// directed tests against an ISA-level register model; expects in-order retires, one per instruction
`default_nettype none

`include "rvPipe_cfg.svh"

module rvPipeTb;

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 3;
    localparam int instBudget  = 120;  // instructions over all tests, rounded up
    localparam int retireWait  = 8;    // latency plus margin
    localparam int numTests    = 6;
    localparam int watchdogCycles = resetCycles + instBudget + numTests * (retireWait + 6);

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;
    } retireT;

    logic                clk;
    logic                reset;
    logic                instValid;
    logic [31:0]         inst;
    logic [`RV_XLEN-1:0] pc;
    logic                flush;
    logic                retireValid;
    logic [`RV_XLEN-1:0] retirePc;
    logic [4:0]          retireRd;
    logic [`RV_XLEN-1:0] retireData;

    logic [`RV_XLEN-1:0] refRegs [`RV_REGS];
    logic [`RV_XLEN-1:0] nextPc;
    retireT              expQ [$];
    retireT              expRetire;
    string               testName;
    int                  errCount;
    int                  checkCount;

    rvPipe rvPipe_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, run did not complete", watchdogCycles);
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    // RV32I integer semantics, alt selects SUB and SRA
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return $signed(a) < $signed(b) ? 32'd1 : 32'd0;
            3'd3:    return a < b ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // returns legality, value is the architectural result
    function automatic logic predict(input logic [31:0] w, input logic [31:0] curPc,
                                     output logic [31:0] value);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] immI;
        f7    = w[31:25];
        f3    = w[14:12];
        immI  = {{20{w[31]}}, w[31:20]};
        value = '0;
        case (w[6:0])
            7'h33: begin
                value = aluRef(f3, f7[5], refRegs[w[19:15]], refRegs[w[24:20]]);
                return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            7'h13: begin
                value = aluRef(f3, f3 == 3'd5 && f7[5], refRegs[w[19:15]], immI);
                case (f3)
                    3'd1:    return f7 == 7'h00;
                    3'd5:    return f7 == 7'h00 || f7 == 7'h20;
                    default: return 1'b1;
                endcase
            end
            7'h37: value = {w[31:12], 12'h000};
            7'h17: value = curPc + {w[31:12], 12'h000};
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // killed marks an instruction that a flush will drop
    task automatic offerInst(input logic [31:0] word, input logic flushNow, input logic killed);
        logic [31:0] value;
        logic        legal;
        @(negedge clk);
        instValid = 1'b1;
        inst      = word;
        pc        = nextPc;
        flush     = flushNow;
        legal     = predict(word, nextPc, value);
        if (legal && !killed) begin
            expQ.push_back('{pc: nextPc, rd: word[11:7], value: value});
            if (word[11:7] != 5'd0) begin
                refRegs[word[11:7]] = value;
            end
        end
        nextPc = nextPc + `RV_PC_STEP;
    endtask

    task automatic issue(input logic [31:0] word);
        offerInst(word, 1'b0, 1'b0);
    endtask

    task automatic idleCycle();
        @(negedge clk);
        instValid = 1'b0;
        flush     = 1'b0;
        inst      = $urandom;   // ignored without instValid
    endtask

    // lui of the rounded upper part, then addi of the sign-extended low part
    task automatic loadReg(input logic [4:0] r, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        issue({hi[31:12], r, 7'h37});
        issue(encI(v[11:0], r, 3'd0, r));
    endtask

    task automatic drain();
        int waited;
        idleCycle();
        waited = 0;
        while (expQ.size() != 0 && waited < retireWait) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            errCount++;
            $display("%s: %0d expected retires never appeared", testName, expQ.size());
            expQ.delete();
        end
        repeat (4) @(negedge clk);  // room for stray retires
    endtask

    always @(negedge clk) begin
        if (!reset && retireValid) begin
            if (expQ.size() == 0) begin
                errCount++;
                $display("%s: unexpected retire of pc %h", testName, retirePc);
            end else begin
                expRetire = expQ.pop_front();
                checkCount++;
                if (retirePc !== expRetire.pc || retireRd !== expRetire.rd
                        || retireData !== expRetire.value) begin
                    errCount++;
                    $display("FAILED %s: expected pc %h rd %0d data %h, actual pc %h rd %0d data %h",
                             testName, expRetire.pc, expRetire.rd, expRetire.value,
                             retirePc, retireRd, retireData);
                end
            end
        end
    end

    task automatic testAluOps();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [4:0]  rsA;
        logic [4:0]  rsB;
        testName = "aluOps";
        for (int r = 1; r <= 4; r++) begin
            loadReg(5'(r), $urandom);
        end
        for (int p = 0; p < 2; p++) begin
            rsA = 5'(1 + 2 * p);
            rsB = 5'(2 + 2 * p);
            for (int i = 0; i < 8; i++) begin
                rnd = $urandom;
                imm = (i == 1 || i == 5) ? {7'h00, rnd[4:0]} : rnd[11:0];
                issue(encR(7'h00, rsB, rsA, i[2:0], 5'(5 + i)));
                issue(encI(imm, rsA, i[2:0], 5'(13 + i)));
            end
            issue(encR(7'h20, rsB, rsA, 3'd0, 5'd21));    // sub
            issue(encR(7'h20, rsB, rsA, 3'd5, 5'd22));    // sra
            issue(encI({7'h20, rnd[9:5]}, rsA, 3'd5, 5'd23));
        end
        drain();
    endtask

    task automatic testForwarding();
        logic [31:0] rnd;
        testName = "forwarding";
        rnd = $urandom;
        issue(encI(rnd[11:0], 5'd0, 3'd0, 5'd10));
        for (int i = 0; i < 5; i++) begin
            rnd = $urandom;
            issue(encI(rnd[11:0], 5'd10, 3'd0, 5'd10));  // distance 1 chain
        end
        issue(encR(7'h00, 5'd10, 5'd10, 3'd0, 5'd11));
        issue(encI(12'd5, 5'd0, 3'd0, 5'd12));
        issue(encR(7'h20, 5'd11, 5'd10, 3'd0, 5'd13));  // distances 3 and 2
        idleCycle();
        issue(encR(7'h00, 5'd13, 5'd12, 3'd4, 5'd14));
        issue(encR(7'h00, 5'd14, 5'd11, 3'd6, 5'd15));
        drain();
    endtask

    task automatic testUpper();
        logic [19:0] up;
        testName = "luiAuipc";
        nextPc = $urandom & 32'hffff_fffc;
        for (int i = 0; i < 4; i++) begin
            up = $urandom;
            issue({up, 5'(16 + i), 7'h37});
            up = $urandom;
            issue({up, 5'(20 + i), 7'h17});
        end
        issue(encR(7'h00, 5'd23, 5'd19, 3'd0, 5'd24));
        drain();
    endtask

    task automatic testX0();
        testName = "x0";
        issue(encI(12'd123, 5'd0, 3'd0, 5'd0));   // retires 123, writes nothing
        issue(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd24));
        issue(encI(12'h055, 5'd1, 3'd0, 5'd0));
        issue(encI(12'd1, 5'd0, 3'd0, 5'd25));    // x0 right behind an x0 write
        issue(encR(7'h00, 5'd0, 5'd25, 3'd6, 5'd26));
        issue({20'hfffff, 5'd0, 7'h37});
        drain();
    endtask

    task automatic testFlush();
        testName = "flush";
        loadReg(5'd28, $urandom);
        loadReg(5'd29, $urandom);
        issue(encI(12'd111, 5'd0, 3'd0, 5'd27));  // three before the flush, survives
        offerInst(encI(12'd222, 5'd0, 3'd0, 5'd28), 1'b0, 1'b1);
        offerInst(encI(12'd333, 5'd0, 3'd0, 5'd27), 1'b0, 1'b1);
        offerInst(encI(12'd444, 5'd0, 3'd0, 5'd29), 1'b1, 1'b1);
        issue(encR(7'h00, 5'd28, 5'd27, 3'd0, 5'd30));
        issue(encI(12'd0, 5'd29, 3'd0, 5'd31));
        drain();
    endtask

    task automatic testUnsupported();
        testName = "unsupported";
        issue({7'h00, 5'd2, 5'd1, 3'd2, 5'd7, 7'h23});   // sw
        idleCycle();
        issue(32'h0000_0063);                            // beq
        issue(encR(7'h01, 5'd2, 5'd1, 3'd0, 5'd7));      // mul
        issue(encI({7'h20, 5'd3}, 5'd1, 3'd1, 5'd8));    // slli with bad funct7
        issue(encI(12'd9, 5'd0, 3'd0, 5'd9));
        idleCycle();
        idleCycle();
        issue(32'h0000_006f);                            // jal
        issue(encR(7'h00, 5'd8, 5'd7, 3'd0, 5'd10));
        drain();
    endtask

    initial begin
        void'($urandom(32'hedc4));
        errCount   = 0;
        checkCount = 0;
        reset      = 1'b1;
        instValid  = 1'b0;
        inst       = '0;
        pc         = '0;
        flush      = 1'b0;
        nextPc     = 32'h0000_1000;
        testName   = "reset";
        for (int i = 0; i < `RV_REGS; i++) begin
            refRegs[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        testAluOps();
        testForwarding();
        testUpper();
        testX0();
        testFlush();
        testUnsupported();
        $display("checks %0d errors %0d", checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/rvPipePkg.sv
hdl/writeBackIf.sv
hdl/stageReg.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/rvPipe.sv
bench/rvPipe_assertions.sv
bench/rvPipeTb.sv

// ==== Bender.yml ====
package:
  name: rv_pipe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvPipePkg.sv
      - hdl/writeBackIf.sv
      - hdl/stageReg.sv
      - hdl/regFile.sv
      - hdl/decodeStage.sv
      - hdl/executeStage.sv
      - hdl/resultStage.sv
      - hdl/rvPipe.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/rvPipe_assertions.sv
      - bench/rvPipeTb.sv
